// ==== filelist.f ====
hw/vc_router_pkg.sv
hw/vc_fifo.sv
hw/vc_input_port.sv
hw/vc_switch_alloc.sv
hw/vc_output_port.sv
hw/vc_router.sv
bench/vc_router_assertions.sv
bench/tb_vc_router.sv

// ==== Bender.yml ====
package:
  name: vc_router

sources:
  - hw/vc_router_pkg.sv
  - hw/vc_fifo.sv
  - hw/vc_input_port.sv
  - hw/vc_switch_alloc.sv
  - hw/vc_output_port.sv
  - hw/vc_router.sv
  - target: test
    files:
      - bench/vc_router_assertions.sv
      - bench/tb_vc_router.sv

// ==== bench/tb_vc_router.sv ====
// ========================================
// vc router testbench
// random credit-respecting sources, a
// stalling sink and a per-stream scoreboard
// ========================================

`timescale 1ns/10ps

module tb_vc_router;

  import vc_router_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int WaitLimit = 2000;

  typedef struct packed {
    port_id_t out_port;
    vc_id_t   vc;
    port_id_t src;
  } route_t;

  typedef struct packed {
    vc_id_t      vc;
    int unsigned due;
  } pend_t;

  logic clk_i;
  logic rst_n_i;
  link_t [NumPorts-1:0]   in_link_bus;
  credit_t [NumPorts-1:0] in_credit_bus;
  link_t [NumPorts-1:0]   out_link_bus;
  credit_t [NumPorts-1:0] out_credit_bus;
  link_t   in_link [NumPorts] = '{default: '0};
  credit_t out_credit [NumPorts] = '{default: '0};

  // source control where a negative value means random
  int src_req [NumPorts];
  int src_fix_vc [NumPorts];
  int src_fix_dst [NumPorts];
  bit hold [NumPorts][NumVC];

  int           sent_cnt [NumPorts];
  int           src_credit [NumPorts][NumVC];
  int           credit_rx [NumPorts][NumVC];
  byte unsigned seq_cnt [NumPorts][NumVC][NumPorts];
  time          drive_time [NumPorts];
  time          credit_time [NumPorts];
  flit_t        exp_q [NumPorts][NumVC][NumPorts][$];
  int           delivered [NumPorts][NumVC];
  int           out_vc_cnt [NumPorts][NumVC];
  time          out_time [NumPorts];
  pend_t        pend_q [NumPorts][$];

  vc_router dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_link_i    (in_link_bus),
    .in_credit_o  (in_credit_bus),
    .out_link_o   (out_link_bus),
    .out_credit_i (out_credit_bus)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // output port, vc and stream key of a sent flit
  function automatic route_t expected_route(input flit_t f, input int src);
    route_t r;
    r.out_port = f.hdr.dst_port;
    r.vc       = f.hdr.vc_id;
    r.src      = port_id_t'(src);
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
      $display("** FAIL **");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  for (genvar p = 0; p < NumPorts; p++) begin : gen_src
    assign in_link_bus[p] = in_link[p];

    always @(posedge clk_i) begin : src_proc
      flit_t  f;
      route_t r;
      int     vc;
      int     dst;
      if (!rst_n_i) begin
        in_link[p] <= '0;
        for (int v = 0; v < NumVC; v++) src_credit[p][v] = VCDepth;
      end else begin
        if (in_credit_bus[p].valid) begin
          src_credit[p][in_credit_bus[p].vc_id]++;
          credit_rx[p][in_credit_bus[p].vc_id]++;
          credit_time[p] = $time;
          check_value("source credit overflow", src_credit[p][in_credit_bus[p].vc_id] > VCDepth, 0);
        end
        vc  = (src_fix_vc[p] < 0) ? $urandom_range(NumVC - 1, 0) : src_fix_vc[p];
        dst = (src_fix_dst[p] < 0) ? $urandom_range(NumPorts - 1, 0) : src_fix_dst[p];
        if (sent_cnt[p] < src_req[p] && src_credit[p][vc] > 0) begin
          f.hdr.dst_port = port_id_t'(dst);
          f.hdr.vc_id    = vc_id_t'(vc);
          f.hdr.src_port = port_id_t'(p);
          f.hdr.seq      = seq_cnt[p][vc][dst];
          f.payload      = $urandom();
          r = expected_route(f, p);
          exp_q[r.src][r.vc][r.out_port].push_back(f);
          seq_cnt[p][vc][dst]++;
          src_credit[p][vc]--;
          sent_cnt[p]++;
          drive_time[p] = $time;
          in_link[p] <= {1'b1, f};
        end else begin
          in_link[p] <= '0;
        end
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_sink
    assign out_credit_bus[o] = out_credit[o];

    // compare every flit leaving this output with the head of its stream
    always @(posedge clk_i) begin : compare_proc
      flit_t got_flit;
      flit_t want_flit;
      if (rst_n_i && out_link_bus[o].valid) begin
        got_flit = out_link_bus[o].flit;
        if (exp_q[got_flit.hdr.src_port][got_flit.hdr.vc_id][o].size() == 0) begin
          report_failure($sformatf("flit on output %0d matches no sent flit", o));
        end else begin
          want_flit = exp_q[got_flit.hdr.src_port][got_flit.hdr.vc_id][o].pop_front();
          check_value($sformatf("flit on output %0d", o), got_flit, want_flit);
          delivered[got_flit.hdr.src_port][got_flit.hdr.vc_id]++;
          out_vc_cnt[o][got_flit.hdr.vc_id]++;
          out_time[o] = $time;
        end
      end
    end

    // credits go back after a random delay and never while the vc is held
    always @(posedge clk_i) begin : sink_proc
      pend_t       ent;
      int          idx;
      int unsigned cyc;
      if (!rst_n_i) begin
        out_credit[o] <= '0;
        cyc = 0;
      end else begin
        cyc++;
        if (out_link_bus[o].valid) begin
          ent.vc  = out_link_bus[o].flit.hdr.vc_id;
          ent.due = cyc + $urandom_range(6, 0);
          pend_q[o].push_back(ent);
        end
        idx = -1;
        for (int i = 0; i < pend_q[o].size(); i++) begin
          if (idx < 0 && pend_q[o][i].due <= cyc && !hold[o][pend_q[o][i].vc]) idx = i;
        end
        if (idx >= 0) begin
          out_credit[o] <= {1'b1, pend_q[o][idx].vc};
          pend_q[o].delete(idx);
        end else begin
          out_credit[o] <= '0;
        end
      end
    end
  end

  function automatic bit drained();
    bit d;
    d = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      d &= (sent_cnt[p] == src_req[p]) && (pend_q[p].size() == 0);
      for (int v = 0; v < NumVC; v++) begin
        for (int q = 0; q < NumPorts; q++) d &= (exp_q[p][v][q].size() == 0);
      end
    end
    return d;
  endfunction

  task automatic wait_for_drain(input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!drained()) begin
      n++;
      if (n > WaitLimit) report_failure($sformatf("%s never drained", what));
      @(negedge clk_i);
    end
    repeat (2) @(posedge clk_i);
  endtask

  task automatic wait_for_count(input int o, input int v, input int target, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (out_vc_cnt[o][v] < target) begin
      n++;
      if (n > WaitLimit) report_failure($sformatf("%s never reached the output", what));
      @(negedge clk_i);
    end
  endtask

  task automatic start_burst(input int p, input int n, input int vc, input int dst);
    @(posedge clk_i);
    src_fix_vc[p]  <= vc;
    src_fix_dst[p] <= dst;
    src_req[p]     <= src_req[p] + n;
  endtask

  initial begin : main_seq
    time t_in;
    int  base;
    void'($urandom(32'h36fc_759d));
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      src_fix_vc[p]  = -1;
      src_fix_dst[p] = -1;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // quiet until the first flit
    repeat (4) begin
      @(negedge clk_i);
      for (int p = 0; p < NumPorts; p++) begin
        check_value("output valid after reset", out_link_bus[p].valid, 0);
        check_value("input credit valid after reset", in_credit_bus[p].valid, 0);
      end
    end

    // the input edge of a lone flit is one cycle after its drive edge
    start_burst(0, 1, 1, 1);
    wait_for_count(1, 1, 1, "lone flit");
    t_in = drive_time[0] + ClkPeriod;
    check_value("idle latency in cycles", (out_time[1] - t_in) / ClkPeriod, 2);
    check_value("input credit time of lone flit", credit_time[0], out_time[1]);
    wait_for_drain("lone flit");

    start_burst(0, 60, -1, -1);
    start_burst(1, 60, -1, -1);
    wait_for_drain("random traffic");

    // starve output 0 vc 0 of credits
    @(posedge clk_i);
    hold[0][0] <= 1'b1;
    base = out_vc_cnt[0][0];
    start_burst(0, 8, 0, 0);
    wait_for_count(0, 0, base + VCDepth, "flits ahead of the stall");
    repeat (20) @(negedge clk_i);
    check_value("flits past a starved vc", out_vc_cnt[0][0] - base, VCDepth);
    @(posedge clk_i);
    hold[0][0] <= 1'b0;
    wait_for_drain("stalled vc");

    start_burst(0, 40, -1, 0);
    start_burst(1, 40, -1, 0);
    wait_for_drain("contention traffic");

    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        check_value("credits returned against flits delivered", credit_rx[p][v], delivered[p][v]);
        check_value("source credits at the end", src_credit[p][v], VCDepth);
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== bench/vc_router_assertions.sv ====
// ========================================
// vc router assertions
// credit and reset checks on output ports
// ========================================

`timescale 1ns/10ps

module vc_router_assertions (
  input logic                                                  clk_i,
  input logic                                                  rst_n_i,
  input logic                                                  send_v_i,
  input vc_router_pkg::flit_t                                  send_flit_i,
  input vc_router_pkg::credit_t                                credit_i,
  input vc_router_pkg::credit_cnt_t [vc_router_pkg::NumVC-1:0] credit_cnt_i,
  input vc_router_pkg::link_t                                  link_i
);

  import vc_router_pkg::*;

  // a flit reaches the link only on a vc that still held a credit
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    send_v_i |-> (credit_cnt_i[send_flit_i.hdr.vc_id] != '0))
    else $error("flit sent on a vc without credit");

  // a credit that comes back while its counter is already full was never owed
  for (genvar v = 0; v < NumVC; v++) begin : gen_cnt
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (credit_i.valid && (credit_i.vc_id == vc_id_t'(v))) |->
        (credit_cnt_i[v] != credit_cnt_t'(VCDepth)))
      else $error("credit counter above buffer depth");
  end

  assert property (@(posedge clk_i) !rst_n_i |=> (!link_i.valid && !credit_i.valid))
    else $error("valid high in the cycle after reset");

endmodule

bind vc_output_port vc_router_assertions i_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .send_v_i     (send_v_i),
  .send_flit_i  (send_flit_i),
  .credit_i     (credit_i),
  .credit_cnt_i (credit_cnt_q),
  .link_i       (link_o)
);

// ==== hw/vc_router.sv ====
// ========================================
// vc router top
// two input ports, switch allocator,
// crossbar and two output ports
// ========================================

`timescale 1ns/10ps

module vc_router (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  vc_router_pkg::link_t [vc_router_pkg::NumPorts-1:0]   in_link_i,
  output vc_router_pkg::credit_t [vc_router_pkg::NumPorts-1:0] in_credit_o,
  output vc_router_pkg::link_t [vc_router_pkg::NumPorts-1:0]   out_link_o,
  input  vc_router_pkg::credit_t [vc_router_pkg::NumPorts-1:0] out_credit_i
);

  import vc_router_pkg::*;

  req_t [NumPorts-1:0]                 req;
  hdr_t [NumPorts-1:0][NumVC-1:0]      head_hdr;
  payload_t [NumPorts-1:0][NumVC-1:0]  head_payload;
  logic [NumPorts-1:0][NumVC-1:0]      credit_avail;

  logic [NumPorts-1:0]                 in_grant_v;
  vc_id_t [NumPorts-1:0]               in_grant_vc;
  logic [NumPorts-1:0]                 out_grant_v;
  port_id_t [NumPorts-1:0]             out_grant_in;
  vc_id_t [NumPorts-1:0]               out_grant_vc;

  flit_t [NumPorts-1:0]                send_flit;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in_port
    vc_input_port i_in_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .link_i         (in_link_i[p]),
      .credit_o       (in_credit_o[p]),
      .req_o          (req[p]),
      .head_hdr_o     (head_hdr[p]),
      .head_payload_o (head_payload[p]),
      .pop_v_i        (in_grant_v[p]),
      .pop_vc_i       (in_grant_vc[p])
    );
  end

  vc_switch_alloc i_switch_alloc (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req),
    .credit_avail_i (credit_avail),
    .in_grant_v_o   (in_grant_v),
    .in_grant_vc_o  (in_grant_vc),
    .out_grant_v_o  (out_grant_v),
    .out_grant_in_o (out_grant_in),
    .out_grant_vc_o (out_grant_vc)
  );

  // each output takes the head flit of its granted input and vc
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      send_flit[o].hdr     = head_hdr[out_grant_in[o]][out_grant_vc[o]];
      send_flit[o].payload = head_payload[out_grant_in[o]][out_grant_vc[o]];
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_out_port
    vc_output_port i_out_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .send_v_i       (out_grant_v[p]),
      .send_flit_i    (send_flit[p]),
      .credit_i       (out_credit_i[p]),
      .credit_avail_o (credit_avail[p]),
      .link_o         (out_link_o[p])
    );
  end

endmodule

// ==== hw/vc_output_port.sv ====
// ========================================
// vc output port
// per-vc credit counters and the switch
// traversal register onto the link
// ========================================

`timescale 1ns/10ps

module vc_output_port (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             send_v_i,
  input  vc_router_pkg::flit_t             send_flit_i,
  input  vc_router_pkg::credit_t           credit_i,
  output logic [vc_router_pkg::NumVC-1:0]  credit_avail_o,
  output vc_router_pkg::link_t             link_o
);

  import vc_router_pkg::*;

  credit_cnt_t [NumVC-1:0] credit_cnt_q;
  logic [NumVC-1:0]        cnt_inc;
  logic [NumVC-1:0]        cnt_dec;

  logic  link_v_q;
  flit_t link_flit_q;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      cnt_inc[v]        = credit_i.valid && (credit_i.vc_id == vc_id_t'(v));
      cnt_dec[v]        = send_v_i && (send_flit_i.hdr.vc_id == vc_id_t'(v));
      credit_avail_o[v] = (credit_cnt_q[v] != '0);
    end
  end

  // credit back and send on the same vc cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_cnt_q[v] <= credit_cnt_t'(VCDepth);
      end
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (cnt_inc[v] && !cnt_dec[v]) begin
          credit_cnt_q[v] <= credit_cnt_q[v] + 1'b1;
        end else if (cnt_dec[v] && !cnt_inc[v]) begin
          credit_cnt_q[v] <= credit_cnt_q[v] - 1'b1;
        end
      end
    end
  end

  // switch traversal stage
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      link_v_q <= 1'b0;
    end else begin
      link_v_q <= send_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_v_i) begin
      link_flit_q <= send_flit_i;
    end
  end

  assign link_o.valid = link_v_q;
  assign link_o.flit  = link_flit_q;

endmodule

// ==== hw/vc_switch_alloc.sv ====
// ========================================
// vc switch allocator
// separable round-robin, input stage then
// output stage, gated by output credits
// ========================================

`timescale 1ns/10ps

module vc_switch_alloc (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  vc_router_pkg::req_t [vc_router_pkg::NumPorts-1:0]            req_i,
  // indexed by output port, then vc
  input  logic [vc_router_pkg::NumPorts-1:0][vc_router_pkg::NumVC-1:0] credit_avail_i,
  output logic [vc_router_pkg::NumPorts-1:0]                           in_grant_v_o,
  output vc_router_pkg::vc_id_t [vc_router_pkg::NumPorts-1:0]          in_grant_vc_o,
  output logic [vc_router_pkg::NumPorts-1:0]                           out_grant_v_o,
  output vc_router_pkg::port_id_t [vc_router_pkg::NumPorts-1:0]        out_grant_in_o,
  output vc_router_pkg::vc_id_t [vc_router_pkg::NumPorts-1:0]          out_grant_vc_o
);

  import vc_router_pkg::*;

  // round-robin pointers naming the highest priority candidate
  vc_id_t [NumPorts-1:0]   in_ptr_q;
  port_id_t [NumPorts-1:0] out_ptr_q;

  // stage one winners per input
  logic [NumPorts-1:0]     s1_v;
  vc_id_t [NumPorts-1:0]   s1_vc;
  port_id_t [NumPorts-1:0] s1_dst;

  // stage one picks one vc per input whose destination still has a credit
  always_comb begin
    int vc_idx;
    for (int i = 0; i < NumPorts; i++) begin
      s1_v[i]  = 1'b0;
      s1_vc[i] = '0;
      for (int k = 0; k < NumVC; k++) begin
        vc_idx = (int'(in_ptr_q[i]) + k) % NumVC;
        if (!s1_v[i] && req_i[i].head_v[vc_idx] &&
            credit_avail_i[req_i[i].dst_port[vc_idx]][vc_idx]) begin
          s1_v[i]  = 1'b1;
          s1_vc[i] = vc_id_t'(vc_idx);
        end
      end
      s1_dst[i] = req_i[i].dst_port[s1_vc[i]];
    end
  end

  // stage two picks one input per output among the stage one winners
  always_comb begin
    int in_idx;
    for (int o = 0; o < NumPorts; o++) begin
      out_grant_v_o[o]  = 1'b0;
      out_grant_in_o[o] = '0;
      for (int k = 0; k < NumPorts; k++) begin
        in_idx = (int'(out_ptr_q[o]) + k) % NumPorts;
        if (!out_grant_v_o[o] && s1_v[in_idx] && (s1_dst[in_idx] == port_id_t'(o))) begin
          out_grant_v_o[o]  = 1'b1;
          out_grant_in_o[o] = port_id_t'(in_idx);
        end
      end
      out_grant_vc_o[o] = s1_vc[out_grant_in_o[o]];
    end
  end

  // an input is granted only if it also won its output
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      in_grant_v_o[i]  = s1_v[i] && out_grant_v_o[s1_dst[i]] &&
                         (out_grant_in_o[s1_dst[i]] == port_id_t'(i));
      in_grant_vc_o[i] = s1_vc[i];
    end
  end

  // pointers move just past the winner and only on a real grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_ptr_q  <= '0;
      out_ptr_q <= '0;
    end else begin
      for (int i = 0; i < NumPorts; i++) begin
        if (in_grant_v_o[i]) begin
          in_ptr_q[i] <= vc_id_t'((int'(s1_vc[i]) + 1) % NumVC);
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (out_grant_v_o[o]) begin
          out_ptr_q[o] <= port_id_t'((int'(out_grant_in_o[o]) + 1) % NumPorts);
        end
      end
    end
  end

endmodule

// ==== hw/vc_input_port.sv ====
// ========================================
// vc input port
// per-vc header and payload buffers, head
// export and upstream credit return
// ========================================

`timescale 1ns/10ps

module vc_input_port (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  vc_router_pkg::link_t                                 link_i,
  output vc_router_pkg::credit_t                               credit_o,
  output vc_router_pkg::req_t                                  req_o,
  output vc_router_pkg::hdr_t [vc_router_pkg::NumVC-1:0]       head_hdr_o,
  output vc_router_pkg::payload_t [vc_router_pkg::NumVC-1:0]   head_payload_o,
  input  logic                                                 pop_v_i,
  input  vc_router_pkg::vc_id_t                                pop_vc_i
);

  import vc_router_pkg::*;

  logic [NumVC-1:0] push_vc;
  logic [NumVC-1:0] pop_vc;
  logic [NumVC-1:0] head_v;

  logic   credit_v_q;
  vc_id_t credit_vc_q;

  // steer the arriving flit by its header vc and decode the grant into a pop
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      push_vc[v] = link_i.valid && (link_i.flit.hdr.vc_id == vc_id_t'(v));
      pop_vc[v]  = pop_v_i && (pop_vc_i == vc_id_t'(v));
    end
  end

  for (genvar v = 0; v < NumVC; v++) begin : gen_vc_buf
    // the header buffer valid is the head valid of the vc
    vc_fifo #(
      .data_t (hdr_t),
      .Depth  (VCDepth)
    ) i_hdr_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_vc[v]),
      .data_i  (link_i.flit.hdr),
      .pop_i   (pop_vc[v]),
      .data_o  (head_hdr_o[v]),
      .valid_o (head_v[v]),
      .full_o  ()
    );

    // payload buffer moves in lockstep with the header buffer
    vc_fifo #(
      .data_t (payload_t),
      .Depth  (VCDepth)
    ) i_payload_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_vc[v]),
      .data_i  (link_i.flit.payload),
      .pop_i   (pop_vc[v]),
      .data_o  (head_payload_o[v]),
      .valid_o (),
      .full_o  ()
    );
  end

  always_comb begin
    req_o.head_v = head_v;
    for (int v = 0; v < NumVC; v++) begin
      req_o.dst_port[v] = head_hdr_o[v].dst_port;
    end
  end

  // credit pulses one cycle after the pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_v_q <= 1'b0;
    end else begin
      credit_v_q <= pop_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_vc_q <= pop_vc_i;
  end

  assign credit_o.valid = credit_v_q;
  assign credit_o.vc_id = credit_vc_q;

endmodule

// ==== hw/vc_fifo.sv ====
// ========================================
// vc fifo
// synchronous circular buffer for any
// payload type, head shown on data_o
// ========================================

`timescale 1ns/10ps

module vc_fifo #(
  parameter type data_t = logic,
  parameter int  Depth  = 3
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  valid_o,
  output logic  full_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  data_t mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic do_push;
  logic do_pop;

  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  assign data_o  = mem_q[rd_ptr_q];

  assign do_pop  = pop_i && valid_o;
  // a full buffer still takes a flit when the head leaves in the same cycle
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== hw/vc_router_pkg.sv ====
// ========================================
// vc router package
// link, flit, credit and request types and
// the fixed router dimensions
// ========================================

package vc_router_pkg;

  // router dimensions
  localparam int NumPorts = 2;
  localparam int NumVC = 2;
  // buffer slots per vc and the initial credit count
  localparam int VCDepth = 3;
  localparam int PayloadWidth = 32;

  localparam int PortIdWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int VCIdWidth = (NumVC > 1) ? $clog2(NumVC) : 1;
  // counter has to hold VCDepth itself
  localparam int CreditCntWidth = $clog2(VCDepth + 1);

  typedef logic [PortIdWidth-1:0] port_id_t;
  typedef logic [VCIdWidth-1:0] vc_id_t;
  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [CreditCntWidth-1:0] credit_cnt_t;

  // flit header routed by dst_port only
  typedef struct packed {
    port_id_t   dst_port;
    vc_id_t     vc_id;
    port_id_t   src_port;
    logic [7:0] seq;
  } hdr_t;

  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

  // forward direction of a link
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  // backward direction where one pulse frees one slot
  typedef struct packed {
    logic   valid;
    vc_id_t vc_id;
  } credit_t;

  // requested output and head valid for each vc of one input port
  typedef struct packed {
    port_id_t [NumVC-1:0] dst_port;
    logic [NumVC-1:0]     head_v;
  } req_t;

endpackage
